/* include/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_STRB_W      4

// Address bits that pick the slave
`define REGION_MSB      31
`define REGION_LSB      28

`define REGION_SRAM     4'h0
`define REGION_WDT      4'h1
`define REGION_PWM      4'h2

// SRAM geometry, index from addr[9:2]
`define SRAM_WORDS      256
`define SRAM_IDX_W      8

// Watchdog map
`define WDT_EN_OFS      32'h0000_0000
`define WDT_LIVE_OFS    32'h0000_0004
`define WDT_TOCNT_OFS   32'h0000_0008
`define WDT_CNT_W       32

// PWM map
`define PWM_CH          4
`define PWM_CNT_W       16
`define PWM_CTRL_OFS    32'h0000_0000
`define PWM_PER_OFS     32'h0000_0010
`define PWM_DUTY_OFS    32'h0000_0014
`define PWM_CH_STRIDE   32'h0000_0008

`endif

/* hw/soc_pkg.sv */
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

    // Single-beat access from the master port
    typedef struct packed {
        logic                     write;    // 1 = write, 0 = read
        logic [`SOC_ADDR_W-1:0]   addr;
        logic [`SOC_DATA_W-1:0]   wdata;
        logic [`SOC_STRB_W-1:0]   wstrb;    // One bit per byte lane
    } bus_req_t;

    // Same codes as the AXI xRESP field
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0]   rdata;
        resp_e                    resp;
    } bus_rsp_t;

    // Decode target of the latched request
    typedef enum logic [1:0] {
        SLV_SRAM = 2'd0,
        SLV_WDT  = 2'd1,
        SLV_PWM  = 2'd2,
        SLV_NONE = 2'd3
    } slave_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,    // Waiting for a request
        ST_ACCESS = 2'd1,    // Slave select cycle
        ST_RESP   = 2'd2     // Response held until taken
    } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/bus_ctrl.sv */
`default_nettype none

`include "soc_params.svh"

module bus_ctrl (
    input  logic                    axi_clk_i,
    input  logic                    rst_n_i,
    // Master port
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  soc_pkg::bus_req_t       req_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output soc_pkg::bus_rsp_t       rsp_o,
    // Slave side
    output logic                    sram_sel_o,
    output logic                    wdt_sel_o,
    output logic                    pwm_sel_o,
    output soc_pkg::bus_req_t       slv_req_o,
    input  logic [`SOC_DATA_W-1:0]  sram_rdata_i,
    input  logic [`SOC_DATA_W-1:0]  wdt_rdata_i,
    input  logic [`SOC_DATA_W-1:0]  pwm_rdata_i
);

    soc_pkg::ctrl_state_e                   state_q;
    soc_pkg::ctrl_state_e                   state_d;
    soc_pkg::slave_e                        slv_q;
    soc_pkg::slave_e                        slv_d;
    soc_pkg::bus_req_t                      req_q;
    soc_pkg::bus_req_t                      req_cut;
    soc_pkg::bus_rsp_t                      rsp;
    logic [`REGION_MSB-`REGION_LSB:0]       region;
    logic                                   accept;

    assign accept = req_valid_i && (state_q == soc_pkg::ST_IDLE);
    assign region = req_i.addr[`REGION_MSB:`REGION_LSB];

    // Region decode on the incoming request
    always_comb begin
        case (region)
            `REGION_SRAM: slv_d = soc_pkg::SLV_SRAM;
            `REGION_WDT:  slv_d = soc_pkg::SLV_WDT;
            `REGION_PWM:  slv_d = soc_pkg::SLV_PWM;
            default:      slv_d = soc_pkg::SLV_NONE;
        endcase
    end

    // Slaves only ever see their own offset
    always_comb begin
        req_cut = req_i;
        req_cut.addr[`REGION_MSB:`REGION_LSB] = '0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            soc_pkg::ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = soc_pkg::ST_ACCESS;
                end
            end
            soc_pkg::ST_ACCESS: begin
                state_d = soc_pkg::ST_RESP;    // Fixed one-cycle access
            end
            soc_pkg::ST_RESP: begin
                if (rsp_ready_i) begin
                    state_d = soc_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = soc_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge axi_clk_i) begin
        if (!rst_n_i) begin
            state_q <= soc_pkg::ST_IDLE;
            slv_q   <= soc_pkg::SLV_NONE;
        end else begin
            state_q <= state_d;
            if (accept) begin
                slv_q <= slv_d;
            end
        end
    end

    always_ff @(posedge axi_clk_i) begin
        if (accept) begin
            req_q <= req_cut;    // Held for the whole transaction
        end
    end

    // One select, only during ST_ACCESS
    assign sram_sel_o = (state_q == soc_pkg::ST_ACCESS) && (slv_q == soc_pkg::SLV_SRAM);
    assign wdt_sel_o  = (state_q == soc_pkg::ST_ACCESS) && (slv_q == soc_pkg::SLV_WDT);
    assign pwm_sel_o  = (state_q == soc_pkg::ST_ACCESS) && (slv_q == soc_pkg::SLV_PWM);
    assign slv_req_o  = req_q;

    // Slave rdata is registered and holds, so the mux is stable in ST_RESP
    always_comb begin
        rsp.rdata = '0;
        rsp.resp  = soc_pkg::RESP_OKAY;
        case (slv_q)
            soc_pkg::SLV_SRAM: rsp.rdata = sram_rdata_i;
            soc_pkg::SLV_WDT:  rsp.rdata = wdt_rdata_i;
            soc_pkg::SLV_PWM:  rsp.rdata = pwm_rdata_i;
            default:           rsp.resp  = soc_pkg::RESP_DECERR;
        endcase
        if (req_q.write) begin
            rsp.rdata = '0;    // Writes carry no data back
        end
    end

    assign rsp_o       = rsp;
    assign rsp_valid_o = (state_q == soc_pkg::ST_RESP);
    assign req_ready_o = (state_q == soc_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* hw/sram_slave.sv */
`default_nettype none

`include "soc_params.svh"

module sram_slave (
    input  logic                    axi_clk_i,
    input  logic                    sel_i,
    input  soc_pkg::bus_req_t       req_i,
    output logic [`SOC_DATA_W-1:0]  rdata_o
);

    logic [`SOC_DATA_W-1:0]  mem [`SRAM_WORDS];
    logic [`SRAM_IDX_W-1:0]  idx;

    // Word index, upper offset bits alias
    assign idx = req_i.addr[`SRAM_IDX_W+1:2];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge axi_clk_i) begin
        if (sel_i && req_i.write) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (req_i.wstrb[b]) begin
                    mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge axi_clk_i) begin
        if (sel_i && !req_i.write) begin
            rdata_o <= mem[idx];    // Held until the next read
        end
    end

endmodule

`default_nettype wire

/* hw/wdt_slave.sv */
`default_nettype none

`include "soc_params.svh"

module wdt_slave (
    input  logic                    axi_clk_i,
    input  logic                    rst_n_i,
    input  logic                    sel_i,
    input  soc_pkg::bus_req_t       req_i,
    output logic [`SOC_DATA_W-1:0]  rdata_o,
    output logic                    timeout_o
);

    logic                   en_q;
    logic [`WDT_CNT_W-1:0]  tocnt_q;
    logic [`WDT_CNT_W-1:0]  cnt_q;
    logic                   wr;
    logic [`SOC_DATA_W-1:0] rd_val;

    assign wr = sel_i && req_i.write;

    always_ff @(posedge axi_clk_i) begin
        if (!rst_n_i) begin
            en_q      <= 1'b0;
            tocnt_q   <= '0;
            cnt_q     <= '0;
            timeout_o <= 1'b0;
        end else begin
            if (en_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (en_q && (cnt_q >= tocnt_q)) begin
                timeout_o <= 1'b1;    // Sticky until kicked or disabled
            end
            // Register writes override the counting above
            if (wr) begin
                case (req_i.addr)
                    `WDT_EN_OFS: begin
                        en_q <= req_i.wdata[0];
                        if (!req_i.wdata[0]) begin
                            cnt_q     <= '0;
                            timeout_o <= 1'b0;
                        end
                    end
                    `WDT_LIVE_OFS: begin
                        cnt_q     <= '0;    // Kick, data ignored
                        timeout_o <= 1'b0;
                    end
                    `WDT_TOCNT_OFS: tocnt_q <= req_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (req_i.addr)
            `WDT_EN_OFS:    rd_val = {{(`SOC_DATA_W-1){1'b0}}, en_q};
            `WDT_LIVE_OFS:  rd_val = cnt_q;    // Live counter value
            `WDT_TOCNT_OFS: rd_val = tocnt_q;
            default:        rd_val = '0;
        endcase
    end

    always_ff @(posedge axi_clk_i) begin
        if (sel_i && !req_i.write) begin
            rdata_o <= rd_val;
        end
    end

endmodule

`default_nettype wire

/* hw/pwm_slave.sv */
`default_nettype none

`include "soc_params.svh"

module pwm_slave (
    input  logic                    axi_clk_i,
    input  logic                    rst_n_i,
    input  logic                    sel_i,
    input  soc_pkg::bus_req_t       req_i,
    output logic [`SOC_DATA_W-1:0]  rdata_o,
    output logic [`PWM_CH-1:0]      pwm_o
);

    logic [`PWM_CH-1:0]     ctrl_q;    // Per-channel enable
    logic [`PWM_CNT_W-1:0]  per_q  [`PWM_CH];
    logic [`PWM_CNT_W-1:0]  duty_q [`PWM_CH];
    logic [`PWM_CNT_W-1:0]  cnt_q  [`PWM_CH];
    logic                   wr;
    logic [`SOC_DATA_W-1:0] rd_val;

    assign wr = sel_i && req_i.write;

    always_ff @(posedge axi_clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
            pwm_o  <= '0;
            for (int c = 0; c < `PWM_CH; c++) begin
                per_q[c]  <= '0;
                duty_q[c] <= '0;
                cnt_q[c]  <= '0;
            end
        end else begin
            for (int c = 0; c < `PWM_CH; c++) begin
                // Counter runs 0 .. period-1, parked at 0 when disabled
                if (!ctrl_q[c]) begin
                    cnt_q[c] <= '0;
                end else if (({1'b0, cnt_q[c]} + 1'b1) >= {1'b0, per_q[c]}) begin
                    cnt_q[c] <= '0;
                end else begin
                    cnt_q[c] <= cnt_q[c] + 1'b1;
                end
                // Zero period or zero duty keeps the pin low
                pwm_o[c] <= ctrl_q[c] && (per_q[c] != '0) && (cnt_q[c] < duty_q[c]);
            end
            if (wr) begin
                if (req_i.addr == `PWM_CTRL_OFS) begin
                    ctrl_q <= req_i.wdata[`PWM_CH-1:0];
                end
                for (int c = 0; c < `PWM_CH; c++) begin
                    if (req_i.addr == `PWM_PER_OFS + c * `PWM_CH_STRIDE) begin
                        per_q[c] <= req_i.wdata[`PWM_CNT_W-1:0];
                    end
                    if (req_i.addr == `PWM_DUTY_OFS + c * `PWM_CH_STRIDE) begin
                        duty_q[c] <= req_i.wdata[`PWM_CNT_W-1:0];
                    end
                end
            end
        end
    end

    // Readback of stored values, zero elsewhere
    always_comb begin
        rd_val = '0;
        if (req_i.addr == `PWM_CTRL_OFS) begin
            rd_val = {{(`SOC_DATA_W-`PWM_CH){1'b0}}, ctrl_q};
        end
        for (int c = 0; c < `PWM_CH; c++) begin
            if (req_i.addr == `PWM_PER_OFS + c * `PWM_CH_STRIDE) begin
                rd_val = {{(`SOC_DATA_W-`PWM_CNT_W){1'b0}}, per_q[c]};
            end
            if (req_i.addr == `PWM_DUTY_OFS + c * `PWM_CH_STRIDE) begin
                rd_val = {{(`SOC_DATA_W-`PWM_CNT_W){1'b0}}, duty_q[c]};
            end
        end
    end

    always_ff @(posedge axi_clk_i) begin
        if (sel_i && !req_i.write) begin
            rdata_o <= rd_val;
        end
    end

endmodule

`default_nettype wire

/* hw/soc_top.sv */
`default_nettype none

`include "soc_params.svh"

module soc_top (
    input  logic                axi_clk_i,
    input  logic                rst_n_i,
    // Master port, driven by the CPU side
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  soc_pkg::bus_req_t   req_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output soc_pkg::bus_rsp_t   rsp_o,
    // Peripheral pins
    output logic                wdt_timeout_o,
    output logic [`PWM_CH-1:0]  pwm_o
);

    logic                    sram_sel;
    logic                    wdt_sel;
    logic                    pwm_sel;
    soc_pkg::bus_req_t       slv_req;    // Shared by all slaves, offset only
    logic [`SOC_DATA_W-1:0]  sram_rdata;
    logic [`SOC_DATA_W-1:0]  wdt_rdata;
    logic [`SOC_DATA_W-1:0]  pwm_rdata;

    bus_ctrl ctrl (
        .axi_clk_i    (axi_clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_o        (rsp_o),
        .sram_sel_o   (sram_sel),
        .wdt_sel_o    (wdt_sel),
        .pwm_sel_o    (pwm_sel),
        .slv_req_o    (slv_req),
        .sram_rdata_i (sram_rdata),
        .wdt_rdata_i  (wdt_rdata),
        .pwm_rdata_i  (pwm_rdata)
    );

    sram_slave sram (
        .axi_clk_i (axi_clk_i),
        .sel_i     (sram_sel),
        .req_i     (slv_req),
        .rdata_o   (sram_rdata)
    );

    wdt_slave wdt (
        .axi_clk_i (axi_clk_i),
        .rst_n_i   (rst_n_i),
        .sel_i     (wdt_sel),
        .req_i     (slv_req),
        .rdata_o   (wdt_rdata),
        .timeout_o (wdt_timeout_o)
    );

    pwm_slave pwm (
        .axi_clk_i (axi_clk_i),
        .rst_n_i   (rst_n_i),
        .sel_i     (pwm_sel),
        .req_i     (slv_req),
        .rdata_o   (pwm_rdata),
        .pwm_o     (pwm_o)
    );

endmodule

`default_nettype wire

/* bench/tb_soc.sv */
`default_nettype none

`include "soc_params.svh"

module tb_soc;

    localparam int WAIT_LIMIT = 64;    // Cycles allowed for any handshake

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    logic               req_ready;
    soc_pkg::bus_req_t  req;
    logic               rsp_valid;
    logic               rsp_ready;
    soc_pkg::bus_rsp_t  rsp;
    logic               wdt_timeout;
    logic [`PWM_CH-1:0] pwm;

    // Shadow registers of the reference model
    logic [`SOC_DATA_W-1:0] sram_model [`SRAM_WORDS];
    logic                   wdt_en_model;
    logic [`WDT_CNT_W-1:0]  wdt_tocnt_model;
    logic [`PWM_CH-1:0]     pwm_ctrl_model;
    logic [`PWM_CNT_W-1:0]  pwm_per_model [`PWM_CH];
    logic [`PWM_CNT_W-1:0]  pwm_duty_model [`PWM_CH];

    string              name_q [$];    // Test name per issued access
    soc_pkg::bus_rsp_t  exp_q [$];
    soc_pkg::bus_rsp_t  act_q [$];
    event               rsp_done;
    int                 issued = 0;
    int                 checked = 0;

    soc_top uut (
        .axi_clk_i     (clk),
        .rst_n_i       (rst_n),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .req_i         (req),
        .rsp_valid_o   (rsp_valid),
        .rsp_ready_i   (rsp_ready),
        .rsp_o         (rsp),
        .wdt_timeout_o (wdt_timeout),
        .pwm_o         (pwm)
    );

    always #20 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            fail_run($sformatf("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act));
        end
    endtask

    function automatic soc_pkg::bus_req_t make_req(input logic wr, input logic [3:0] region,
            input logic [31:0] ofs, input logic [31:0] wdata, input logic [3:0] strb);
        return {wr, region, ofs[`REGION_LSB-1:0], wdata, strb};
    endfunction

    // Expected response from the bus rules, shadows updated on writes
    function automatic soc_pkg::bus_rsp_t ref_access(input soc_pkg::bus_req_t r);
        soc_pkg::bus_rsp_t      e;
        logic [`SOC_ADDR_W-1:0] ofs;
        logic [`SRAM_IDX_W-1:0] idx;
        e.rdata = '0;
        e.resp  = soc_pkg::RESP_OKAY;
        ofs = {4'h0, r.addr[`REGION_LSB-1:0]};
        idx = ofs[`SRAM_IDX_W+1:2];    // Upper offset bits alias
        case (r.addr[`REGION_MSB:`REGION_LSB])
            `REGION_SRAM: begin
                for (int b = 0; b < `SOC_STRB_W; b++) begin
                    if (r.write && r.wstrb[b])
                        sram_model[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
                end
                e.rdata = sram_model[idx];
            end
            `REGION_WDT: begin
                if (r.write && ofs == `WDT_EN_OFS)
                    wdt_en_model = r.wdata[0];
                if (r.write && ofs == `WDT_TOCNT_OFS)
                    wdt_tocnt_model = r.wdata;
                if (ofs == `WDT_EN_OFS)
                    e.rdata = 32'(wdt_en_model);
                if (ofs == `WDT_TOCNT_OFS)
                    e.rdata = wdt_tocnt_model;
            end
            `REGION_PWM: begin
                if (r.write && ofs == `PWM_CTRL_OFS)
                    pwm_ctrl_model = r.wdata[`PWM_CH-1:0];
                if (ofs == `PWM_CTRL_OFS)
                    e.rdata = 32'(pwm_ctrl_model);
                for (int c = 0; c < `PWM_CH; c++) begin
                    if (r.write && ofs == `PWM_PER_OFS + c * `PWM_CH_STRIDE)
                        pwm_per_model[c] = r.wdata[`PWM_CNT_W-1:0];
                    if (r.write && ofs == `PWM_DUTY_OFS + c * `PWM_CH_STRIDE)
                        pwm_duty_model[c] = r.wdata[`PWM_CNT_W-1:0];
                    if (ofs == `PWM_PER_OFS + c * `PWM_CH_STRIDE)
                        e.rdata = 32'(pwm_per_model[c]);
                    if (ofs == `PWM_DUTY_OFS + c * `PWM_CH_STRIDE)
                        e.rdata = 32'(pwm_duty_model[c]);
                end
            end
            default: e.resp = soc_pkg::RESP_DECERR;    // Unmapped region
        endcase
        if (r.write)
            e.rdata = '0;
        return e;
    endfunction

    // One access on the master port, response stalled for hold cycles
    task automatic bus_access(input string name, input soc_pkg::bus_req_t r, input int hold,
                              output soc_pkg::bus_rsp_t got);
        int waited;
        int lat;
        @(negedge clk);
        waited = 0;
        while (!req_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready)
            fail_run({name, ": req_ready stayed low, the request was never accepted"});
        name_q.push_back(name);
        exp_q.push_back(ref_access(r));
        req       = r;
        req_valid = 1'b1;
        rsp_ready = (hold == 0);
        @(posedge clk);    // Accept edge
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!rsp_valid && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!rsp_valid)
            fail_run({name, ": rsp_valid never rose after the request was accepted"});
        check_equal({name, " latency"}, 2, lat);
        got = rsp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_equal({name, " stalled response"}, {1'b1, got, 1'b0},
                        {rsp_valid, rsp, req_ready});
        end
        rsp_ready = 1'b1;
        @(posedge clk);    // Response transfer
        act_q.push_back(got);
        issued++;
        -> rsp_done;
        @(negedge clk);
        check_equal({name, " req_ready after transfer"}, 1, req_ready);
    endtask

    task automatic write_read(input string name, input logic [3:0] region, input logic [31:0] ofs,
                              input logic [31:0] data);
        soc_pkg::bus_rsp_t got;
        bus_access({name, " write"}, make_req(1'b1, region, ofs, data, 4'hf), 0, got);
        bus_access({name, " read"}, make_req(1'b0, region, ofs, '0, '0), 0, got);
    endtask

    // Watchdog pin must rise within limit cycles
    task automatic wait_wdt_timeout(input string what, input int limit);
        int waited;
        waited = 0;
        while (!wdt_timeout && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!wdt_timeout)
            fail_run({"wdt_timeout_o did not rise within the timeout count plus 10 cycles ",
                      what});
    endtask

    // Responses compared against the reference in issue order
    always @(rsp_done) begin : compare_rsp
        soc_pkg::bus_rsp_t exp_rsp;
        soc_pkg::bus_rsp_t act_rsp;
        while (act_q.size() > 0) begin
            exp_rsp = exp_q.pop_front();
            act_rsp = act_q.pop_front();
            check_equal(name_q.pop_front(), exp_rsp, act_rsp);
            checked++;
        end
    end

    initial begin
        soc_pkg::bus_rsp_t      got;
        logic [`SRAM_IDX_W-1:0] pool [16];
        logic [`PWM_CH-1:0]     en_mask;
        logic [31:0]            ofs;
        int                     per [`PWM_CH];
        int                     duty [`PWM_CH];
        int                     k;
        int                     tocnt;
        int                     dis;
        int                     high_cnt;

        void'($urandom(73571));
        clk             = 1'b0;
        rst_n           = 1'b0;
        req_valid       = 1'b0;
        req             = '0;
        rsp_ready       = 1'b1;
        wdt_en_model    = 1'b0;
        wdt_tocnt_model = '0;
        pwm_ctrl_model  = '0;
        for (int c = 0; c < `PWM_CH; c++) begin
            pwm_per_model[c]  = '0;
            pwm_duty_model[c] = '0;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_equal("reset state", {3'b010, 4'h0}, {rsp_valid, req_ready, wdt_timeout, pwm});

        // SRAM, full-strobe writes define a pool of words first
        for (int i = 0; i < 16; i++) begin
            pool[i] = $urandom_range(255, 0);
            bus_access("sram init write",
                       make_req(1'b1, `REGION_SRAM, {pool[i], 2'b00}, $urandom, 4'hf), 0, got);
        end
        for (int n = 0; n < 40; n++) begin
            k   = $urandom_range(15, 0);
            ofs = ($urandom & 32'h0fff_fc00) | {pool[k], 2'b00};    // Aliased upper bits
            bus_access("sram strobed write", make_req(1'b1, `REGION_SRAM, ofs, $urandom,
                       4'($urandom_range(15, 0))), 0, got);
            k = $urandom_range(15, 0);
            bus_access("sram read",
                       make_req(1'b0, `REGION_SRAM, {pool[k], 2'b00}, '0, '0), 0, got);
        end

        // Unmapped regions answer DECERR and leave the SRAM alone
        for (int code = 3; code < 16; code++) begin
            ofs = {pool[code], 2'b00};
            bus_access("unmapped write", make_req(1'b1, 4'(code), ofs, $urandom, 4'hf), 0, got);
            bus_access("unmapped read", make_req(1'b0, 4'(code), ofs, '0, '0), 0, got);
            bus_access("sram after unmapped write",
                       make_req(1'b0, `REGION_SRAM, ofs, '0, '0), 0, got);
        end

        // Watchdog, first kick only once the pin is already high
        tocnt = $urandom_range(60, 20);
        write_read("wdt timeout count", `REGION_WDT, `WDT_TOCNT_OFS, tocnt);
        write_read("wdt enable", `REGION_WDT, `WDT_EN_OFS, 1);
        wait_wdt_timeout("after enable", tocnt + 10);
        bus_access("wdt kick", make_req(1'b1, `REGION_WDT, `WDT_LIVE_OFS, $urandom, 4'hf), 0, got);
        check_equal("wdt timeout low after kick", 0, wdt_timeout);
        wait_wdt_timeout("after the kick", tocnt + 10);
        bus_access("wdt second kick",
                   make_req(1'b1, `REGION_WDT, `WDT_LIVE_OFS, $urandom, 4'hf), 0, got);
        check_equal("wdt timeout cleared by kick", 0, wdt_timeout);
        write_read("wdt disable", `REGION_WDT, `WDT_EN_OFS, 0);
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            check_equal("wdt timeout while disabled", 0, wdt_timeout);
        end

        // PWM, three of the four channels enabled
        for (int c = 0; c < `PWM_CH; c++) begin
            per[c]  = $urandom_range(40, 4);
            duty[c] = $urandom_range(45, 0);
            write_read("pwm period", `REGION_PWM, `PWM_PER_OFS + c * `PWM_CH_STRIDE, per[c]);
            write_read("pwm duty", `REGION_PWM, `PWM_DUTY_OFS + c * `PWM_CH_STRIDE, duty[c]);
        end
        dis          = $urandom_range(`PWM_CH - 1, 0);
        en_mask      = '1;
        en_mask[dis] = 1'b0;
        write_read("pwm enable", `REGION_PWM, `PWM_CTRL_OFS, en_mask);
        for (int c = 0; c < `PWM_CH; c++) begin
            if (en_mask[c]) begin
                high_cnt = 0;
                for (int i = 0; i < per[c]; i++) begin    // One full period
                    @(negedge clk);
                    high_cnt += pwm[c];
                    check_equal("pwm disabled channel low", 0, pwm[dis]);
                end
                check_equal("pwm high cycles per period",
                            (duty[c] < per[c]) ? duty[c] : per[c], high_cnt);
            end
        end

        // Response stalled by the master for 1 to 15 cycles
        for (int n = 0; n < 12; n++) begin
            k = $urandom_range(15, 0);
            bus_access("stalled sram access", make_req(1'(n % 2), `REGION_SRAM,
                       {pool[k], 2'b00}, $urandom, 4'hf), $urandom_range(15, 1), got);
        end

        repeat (2) @(negedge clk);
        check_equal("responses checked", issued, checked);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
hw/soc_pkg.sv
hw/bus_ctrl.sv
hw/sram_slave.sv
hw/wdt_slave.sv
hw/pwm_slave.sv
hw/soc_top.sv
bench/tb_soc.sv
